// ==== rtl/spm_pkg.sv ====
package spm_pkg;

	// Geometry of the scratchpad.
	localparam int SPM_BANKS     = 8;
	localparam int SPM_ADDR_W    = 7;
	localparam int SPM_DEPTH     = 128;
	localparam int SPM_DATA_W    = 32;

	// Configuration ring.
	localparam int SPM_CFG_DEPTH = 16;
	localparam int SPM_CFG_PTR_W = 4;

	// Width of an external bank select.
	localparam int SPM_SEL_W     = 3;

	// One configuration word, applied for a whole run step.
	// A sel bit of 1 routes the switch port to that bank, 0 the external port.
	typedef struct packed {
		logic [SPM_BANKS-1:0] en;  // Bank enables.
		logic [SPM_BANKS-1:0] sel; // Source selects.
	} spm_inst_t;

	// One access as seen by a bank group.
	typedef struct packed {
		logic [SPM_ADDR_W-1:0] addr;
		logic [SPM_DATA_W-1:0] data;
		logic                  we;  // Write strobe.
		logic                  re;  // Read strobe.
	} spm_access_t;

	// Switch side uses the bank access format as is.
	typedef spm_access_t spm_sw_req_t;

	// External port request.
	typedef struct packed {
		logic [SPM_SEL_W-1:0]  wsel; // Bank to write.
		logic [SPM_SEL_W-1:0]  rsel; // Bank to read.
		logic                  we;
		logic                  re;
		logic [SPM_ADDR_W-1:0] addr;
		logic [SPM_DATA_W-1:0] data;
	} spm_ex_req_t;

	// Read response, one cycle after the request.
	typedef struct packed {
		logic                  valid;
		logic [SPM_DATA_W-1:0] data;
	} spm_rsp_t;

endpackage

// ==== rtl/spm_config_buffer.sv ====
`timescale 1ns/1ps

module spm_config_buffer
	import spm_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      init_i,
	input  logic      run_i,
	input  spm_inst_t inst_i,
	output spm_inst_t cfg_o
);

	spm_inst_t                entries [SPM_CFG_DEPTH];
	logic [SPM_CFG_PTR_W-1:0] wr_ptr;
	logic [SPM_CFG_PTR_W-1:0] rd_ptr;
	spm_inst_t                cfg_q;

	// Write side. Entries are filled in order while init is high.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SPM_CFG_DEPTH; i++) begin
				entries[i] <= '0;
			end
			wr_ptr <= '0;
		end else if (init_i) begin
			entries[wr_ptr] <= inst_i;
			wr_ptr <= wr_ptr + 1'b1; // Wraps at the last entry.
		end
	end

	// Read side. Each run pulse issues the next entry.
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			cfg_q <= '0; // All banks off, external source.
		end else if (!init_i && run_i) begin
			cfg_q <= entries[rd_ptr];
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign cfg_o = cfg_q;

endmodule

// ==== rtl/spm_port_mux.sv ====
`timescale 1ns/1ps

module spm_port_mux
	import spm_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  spm_inst_t                    cfg_i,
	input  spm_sw_req_t [SPM_BANKS-1:0]  sw_i,
	input  spm_ex_req_t                  ex_i,
	input  spm_rsp_t    [SPM_BANKS-1:0]  bank_rsp_i,
	output spm_access_t [SPM_BANKS-1:0]  bank_req_o,
	output logic        [SPM_BANKS-1:0]  bank_en_o,
	output spm_rsp_t                     ex_o
);

	logic [SPM_BANKS-1:0] ex_we_oh;
	logic [SPM_BANKS-1:0] ex_re_oh;
	logic [SPM_SEL_W-1:0] rsel_q;
	logic                 re_q;

	// One-hot strobes for the external port.
	assign ex_we_oh = ex_i.we ? (SPM_BANKS'(1) << ex_i.wsel) : '0;
	assign ex_re_oh = ex_i.re ? (SPM_BANKS'(1) << ex_i.rsel) : '0;

	assign bank_en_o = cfg_i.en;

	// Per bank source steering.
	always_comb begin
		for (int k = 0; k < SPM_BANKS; k++) begin
			if (cfg_i.sel[k]) begin
				bank_req_o[k] = sw_i[k]; // Switch side.
			end else begin
				bank_req_o[k].addr = ex_i.addr;
				bank_req_o[k].data = ex_i.data;
				bank_req_o[k].we   = ex_we_oh[k];
				bank_req_o[k].re   = ex_re_oh[k];
			end
		end
	end

	// Delay the read select to meet the bank read latency.
	always_ff @(posedge clk) begin
		if (rst) begin
			rsel_q <= '0;
			re_q <= 1'b0;
		end else begin
			rsel_q <= ex_i.rsel;
			re_q <= ex_i.re;
		end
	end

	// Switch reads are masked by the delayed external strobe.
	assign ex_o.valid = bank_rsp_i[rsel_q].valid & re_q;
	assign ex_o.data  = bank_rsp_i[rsel_q].data;

endmodule

// ==== rtl/spm_bankgroup.sv ====
`timescale 1ns/1ps

module spm_bankgroup
	import spm_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        en_i,
	input  spm_access_t req_i,
	output spm_rsp_t    rsp_o
);

	logic [SPM_DATA_W-1:0] mem [SPM_DEPTH];
	logic [SPM_DATA_W-1:0] rd_data_q;
	logic                  rd_valid_q;
	logic                  wr_en;
	logic                  rd_en;

	assign wr_en = en_i & req_i.we;
	assign rd_en = en_i & req_i.re;

	// Storage. Contents start out as zero.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SPM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[req_i.addr] <= req_i.data;
		end
	end

	// Registered read, sees the word before a same-cycle write.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data_q <= mem[req_i.addr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= rd_en; // Low when disabled.
		end
	end

	assign rsp_o.valid = rd_valid_q;
	assign rsp_o.data  = rd_data_q;

endmodule

// ==== rtl/scratchpad.sv ====
`timescale 1ns/1ps

module scratchpad
	import spm_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        init_i,
	input  logic                        run_i,
	input  spm_inst_t                   inst_i,
	input  spm_sw_req_t [SPM_BANKS-1:0] sw_i,
	input  spm_ex_req_t                 ex_i,
	output spm_rsp_t    [SPM_BANKS-1:0] sw_o,
	output spm_rsp_t                    ex_o
);

	spm_inst_t                   cfg;
	spm_access_t [SPM_BANKS-1:0] bank_req;
	logic        [SPM_BANKS-1:0] bank_en;

	// Live configuration for the current run step.
	spm_config_buffer cfg_buf_i (
		.clk    (clk),
		.rst    (rst),
		.init_i (init_i),
		.run_i  (run_i),
		.inst_i (inst_i),
		.cfg_o  (cfg)
	);

	spm_port_mux mux_i (
		.clk        (clk),
		.rst        (rst),
		.cfg_i      (cfg),
		.sw_i       (sw_i),
		.ex_i       (ex_i),
		.bank_rsp_i (sw_o), // Bank responses loop back for ex_o.
		.bank_req_o (bank_req),
		.bank_en_o  (bank_en),
		.ex_o       (ex_o)
	);

	for (genvar k = 0; k < SPM_BANKS; k++) begin : g_bank
		spm_bankgroup bank_i (
			.clk   (clk),
			.rst   (rst),
			.en_i  (bank_en[k]),
			.req_i (bank_req[k]),
			.rsp_o (sw_o[k])
		);
	end

endmodule

// ==== test/scratchpad_assertions.sv ====
`timescale 1ns/1ps

module scratchpad_assertions
	import spm_pkg::*;
(
	input logic                        clk,
	input logic                        rst,
	input spm_sw_req_t [SPM_BANKS-1:0] sw_i,
	input spm_ex_req_t                 ex_i,
	input spm_rsp_t    [SPM_BANKS-1:0] sw_o,
	input spm_rsp_t                    ex_o
);

	logic [SPM_BANKS-1:0] sw_valid;

	always_comb begin
		for (int k = 0; k < SPM_BANKS; k++) begin
			sw_valid[k] = sw_o[k].valid;
		end
	end

	// Responses are quiet right out of reset.
	quiet_after_reset: assert property (@(posedge clk)
		rst |=> (sw_valid == '0 && !ex_o.valid))
		else $error("A response valid is high in the cycle after reset.");

	ex_valid_has_read: assert property (@(posedge clk) disable iff (rst)
		ex_o.valid |-> $past(ex_i.re))
		else $error("ex_o valid without an external read one cycle earlier.");

	for (genvar k = 0; k < SPM_BANKS; k++) begin : g_sw
		sw_valid_has_read: assert property (@(posedge clk) disable iff (rst)
			sw_valid[k] |-> $past(sw_i[k].re || ex_i.re))
			else $error("sw_o[%0d] valid without a read one cycle earlier.", k);
	end

endmodule

bind scratchpad scratchpad_assertions asrt_i (.*);

// ==== test/scratchpad_tb.sv ====
`timescale 1ns/1ps

module scratchpad_tb
	import spm_pkg::*;
();

	localparam int    CLK_PERIOD   = 20;
	localparam int    RESET_CYCLES = 3;
	localparam int    SLACK_CYCLES = 20;
	localparam string STIM_FILE    = "test/spm_stimulus.txt";

	logic                        clk;
	logic                        rst;
	logic                        init_i;
	logic                        run_i;
	spm_inst_t                   inst_i;
	spm_sw_req_t [SPM_BANKS-1:0] sw_i;
	spm_ex_req_t                 ex_i;
	spm_rsp_t    [SPM_BANKS-1:0] sw_o;
	spm_rsp_t                    ex_o;

	// Reference model state.
	logic [SPM_DATA_W-1:0] m_mem [SPM_BANKS][SPM_DEPTH];
	spm_inst_t             m_ring [SPM_CFG_DEPTH];
	spm_inst_t             m_cfg;
	int                    m_wr_ptr;
	int                    m_rd_ptr;

	// Model predictions for the cycle after the current request.
	spm_rsp_t    [SPM_BANKS-1:0] pred_sw;
	spm_rsp_t                    pred_ex;
	spm_inst_t                   prev_cfg;
	spm_access_t [SPM_BANKS-1:0] prev_req;

	// Directed expectations taken from the stimulus file.
	logic     pend_ex_on;
	spm_rsp_t pend_ex;
	logic     pend_sw_on;
	int       pend_sw_bank;
	spm_rsp_t pend_sw;

	integer seed;
	int     cycle_cnt   = 0;
	int     cycle_limit = 0;
	int     line_no;

	scratchpad dut_i (
		.clk    (clk),
		.rst    (rst),
		.init_i (init_i),
		.run_i  (run_i),
		.inst_i (inst_i),
		.sw_i   (sw_i),
		.ex_i   (ex_i),
		.sw_o   (sw_o),
		.ex_o   (ex_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: the stimulus did not finish within %0d cycles.", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1, "Simulation stopped by the cycle limit.");
		end
	end

	task automatic check_rsp(input string name, input spm_rsp_t exp, input spm_rsp_t act);
		if (act.valid !== exp.valid || (exp.valid && act.data !== exp.data)) begin
			$display("CHECK FAILED at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "Response mismatch on %s.", name);
		end
	endtask

	// Valid must follow the bank enable of the step in which the read was issued.
	task automatic check_inst_effect(input int k, input spm_inst_t cfg, input spm_access_t req,
			input spm_rsp_t act);
		logic exp_valid;
		exp_valid = cfg.en[k] & req.re;
		if (act.valid !== exp_valid) begin
			$display("CHECK FAILED at %0t ns: sw_o[%0d].valid expected %b, actual %b",
				$time, k, exp_valid, act.valid);
			$display("*** FAILED ***");
			$fatal(1, "Bank enable not honoured on bank %0d.", k);
		end
	endtask

	task automatic match_model(input spm_rsp_t exp_file, input spm_rsp_t exp_model);
		if (exp_file.valid !== exp_model.valid
				|| (exp_file.valid && exp_file.data !== exp_model.data)) begin
			$display("Stimulus line %0d expects %h but the reference model predicts %h.",
				line_no, exp_file, exp_model);
			$display("*** FAILED ***");
			$fatal(1, "Stimulus file and reference model disagree.");
		end
	endtask

	task automatic reject_line();
		$display("Stimulus line %0d is malformed or names an unknown command.", line_no);
		$display("*** FAILED ***");
		$fatal(1, "Bad stimulus file.");
	endtask

	task automatic check_outputs();
		for (int k = 0; k < SPM_BANKS; k++) begin
			check_inst_effect(k, prev_cfg, prev_req[k], sw_o[k]);
			check_rsp($sformatf("sw_o[%0d]", k), pred_sw[k], sw_o[k]);
		end
		check_rsp("ex_o", pred_ex, ex_o);
		if (pend_ex_on) begin
			check_rsp("ex_o", pend_ex, ex_o);
		end
		if (pend_sw_on) begin
			check_rsp($sformatf("sw_o[%0d]", pend_sw_bank), pend_sw, sw_o[pend_sw_bank]);
		end
		pend_ex_on = 1'b0;
		pend_sw_on = 1'b0;
	endtask

	// Random traffic that never reaches an enabled bank.
	task automatic fill_idle();
		init_i = 1'b0;
		run_i  = 1'b0;
		inst_i = '0;
		for (int k = 0; k < SPM_BANKS; k++) begin
			sw_i[k].addr = SPM_ADDR_W'($random(seed));
			sw_i[k].data = $random(seed);
			sw_i[k].we   = m_cfg.sel[k] ? 1'b0 : 1'($random(seed));
			sw_i[k].re   = m_cfg.sel[k] ? 1'b0 : 1'($random(seed));
		end
		ex_i.wsel = SPM_SEL_W'($random(seed));
		ex_i.rsel = SPM_SEL_W'($random(seed));
		ex_i.we   = 1'b0;
		ex_i.re   = 1'b0;
		ex_i.addr = SPM_ADDR_W'($random(seed));
		ex_i.data = $random(seed);
	endtask

	task automatic model_step();
		spm_access_t [SPM_BANKS-1:0] req;
		for (int k = 0; k < SPM_BANKS; k++) begin
			if (m_cfg.sel[k]) begin
				req[k] = sw_i[k];
			end else begin
				req[k].addr = ex_i.addr;
				req[k].data = ex_i.data;
				req[k].we   = ex_i.we && (ex_i.wsel == k);
				req[k].re   = ex_i.re && (ex_i.rsel == k);
			end
		end
		for (int k = 0; k < SPM_BANKS; k++) begin
			pred_sw[k].valid = m_cfg.en[k] && req[k].re;
			pred_sw[k].data  = pred_sw[k].valid ? m_mem[k][req[k].addr] : '0;
		end
		pred_ex.valid = pred_sw[ex_i.rsel].valid && ex_i.re;
		pred_ex.data  = pred_sw[ex_i.rsel].data;
		prev_cfg = m_cfg;
		prev_req = req;
		for (int k = 0; k < SPM_BANKS; k++) begin
			if (m_cfg.en[k] && req[k].we) begin
				m_mem[k][req[k].addr] = req[k].data; // After the old word was read.
			end
		end
		if (init_i) begin
			m_ring[m_wr_ptr] = inst_i;
			m_wr_ptr = (m_wr_ptr + 1) % SPM_CFG_DEPTH;
		end else if (run_i) begin
			m_cfg = m_ring[m_rd_ptr];
			m_rd_ptr = (m_rd_ptr + 1) % SPM_CFG_DEPTH;
		end
	endtask

	initial begin
		int               fd;
		int               n;
		int               sw_bank;
		logic [8*8-1:0]   cmd;
		logic [8*128-1:0] text;
		logic [31:0]      f_bank;
		logic [31:0]      f_we;
		logic [31:0]      f_wsel;
		logic [31:0]      f_re;
		logic [31:0]      f_rsel;
		logic [31:0]      f_addr;
		logic [31:0]      f_data;
		logic [31:0]      f_ev;
		logic [31:0]      f_ed;
		spm_rsp_t         exp_file;

		seed = 66;
		rst = 1'b1;
		init_i = 1'b0;
		run_i = 1'b0;
		inst_i = '0;
		sw_i = '0;
		ex_i = '0;
		for (int k = 0; k < SPM_BANKS; k++) begin
			for (int a = 0; a < SPM_DEPTH; a++) begin
				m_mem[k][a] = '0;
			end
		end
		for (int i = 0; i < SPM_CFG_DEPTH; i++) begin
			m_ring[i] = '0;
		end
		m_cfg = '0; // All banks off after reset.
		m_wr_ptr = 0;
		m_rd_ptr = 0;
		pred_sw = '0;
		pred_ex = '0;
		prev_cfg = '0;
		prev_req = '0;
		pend_ex_on = 1'b0;
		pend_sw_on = 1'b0;
		pend_sw_bank = 0;
		pend_ex = '0;
		pend_sw = '0;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %s.", STIM_FILE);
			$display("*** FAILED ***");
			$fatal(1, "No stimulus.");
		end
		n = 0;
		while ($fgets(text, fd) != 0) begin
			n++;
		end
		$fclose(fd);
		cycle_limit = n + RESET_CYCLES + SLACK_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst = 1'b0;

		fd = $fopen(STIM_FILE, "r");
		line_no = 0;
		while ($fscanf(fd, "%s", cmd) == 1) begin
			line_no++;
			if (cmd == "#") begin
				n = $fgets(text, fd);
			end else begin
				@(posedge clk);
				#1;
				check_outputs();
				#1;
				fill_idle();
				case (cmd)
					"rchk": begin
						for (int k = 0; k < SPM_BANKS; k++) begin
							check_rsp($sformatf("sw_o[%0d]", k), '0, sw_o[k]);
						end
						check_rsp("ex_o", '0, ex_o);
					end
					"init": begin
						n = $fscanf(fd, "%h", f_data);
						if (n != 1) begin
							reject_line();
						end
						inst_i = f_data[15:0];
						init_i = 1'b1;
					end
					"run": run_i = 1'b1;
					"idle": ;
					"ext": begin
						n = $fscanf(fd, "%h %h %h %h %h %h %h %h", f_we, f_wsel, f_re, f_rsel,
							f_addr, f_data, f_ev, f_ed);
						if (n != 8) begin
							reject_line();
						end
						ex_i.we   = f_we[0];
						ex_i.wsel = f_wsel[SPM_SEL_W-1:0];
						ex_i.re   = f_re[0];
						ex_i.rsel = f_rsel[SPM_SEL_W-1:0];
						ex_i.addr = f_addr[SPM_ADDR_W-1:0];
						ex_i.data = f_data;
					end
					"sw": begin
						n = $fscanf(fd, "%h %h %h %h %h %h %h", f_bank, f_we, f_re, f_addr,
							f_data, f_ev, f_ed);
						if (n != 7 || f_bank >= SPM_BANKS) begin
							reject_line();
						end
						sw_bank = f_bank;
						sw_i[sw_bank].we   = f_we[0];
						sw_i[sw_bank].re   = f_re[0];
						sw_i[sw_bank].addr = f_addr[SPM_ADDR_W-1:0];
						sw_i[sw_bank].data = f_data;
					end
					default: reject_line();
				endcase
				model_step();
				exp_file.valid = f_ev[0];
				exp_file.data  = f_ed;
				if (cmd == "ext") begin
					match_model(exp_file, pred_ex);
					pend_ex_on = 1'b1;
					pend_ex = exp_file;
					if (f_re[0]) begin
						pend_sw_on = 1'b1; // Same word shows on the bank's own port.
						pend_sw_bank = f_rsel[SPM_SEL_W-1:0];
						pend_sw = exp_file;
					end
				end else if (cmd == "sw") begin
					match_model(exp_file, pred_sw[sw_bank]);
					pend_sw_on = 1'b1;
					pend_sw_bank = sw_bank;
					pend_sw = exp_file;
				end
			end
		end
		$fclose(fd);

		@(posedge clk);
		#1;
		check_outputs();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== test/spm_stimulus.txt ====
# cmd fields in hex: init inst | run | idle | rchk | ext we wsel re rsel addr data exp_v exp_d
# sw bank we re addr data exp_v exp_d ; exp_v and exp_d are the response one cycle later
rchk
ext 1 0 0 0 05 deadbeef 0 00000000
# configuration ring, inst is en then sel
init ff00
init ff0f
init 0f00
init ff00
init f0f0
init 0ff0
init ff00
init ff55
init ffaa
init ff00
init 3c00
init ff00
init c3ff
init ff00
init ff0f
init 0000
run
ext 0 0 1 0 05 00000000 1 00000000
ext 1 3 0 0 10 11223344 0 00000000
ext 0 0 1 3 10 00000000 1 11223344
ext 1 3 1 3 10 55667788 1 11223344
ext 0 0 1 3 10 00000000 1 55667788
# banks 0 to 3 on the switch port
run
sw 1 1 0 20 cafe0001 0 00000000
ext 1 1 0 0 20 bad00001 0 00000000
sw 1 0 1 20 00000000 1 cafe0001
sw 2 1 1 7f 12345678 1 00000000
sw 2 0 1 7f 00000000 1 12345678
ext 1 4 0 0 00 44440000 0 00000000
ext 0 0 1 1 20 00000000 0 00000000
# banks 4 to 7 disabled
run
ext 1 4 0 0 00 99990000 0 00000000
ext 0 0 1 4 00 00000000 0 00000000
ext 0 0 1 1 20 00000000 1 cafe0001
run
ext 0 0 1 4 00 00000000 1 44440000
run
run
run
run
run
run
run
run
run
run
run
run
ext 1 5 0 0 33 0badf00d 0 00000000
# wrap back to entry 0
run
ext 0 0 1 5 33 00000000 1 00000000
ext 0 0 1 1 20 00000000 1 cafe0001
ext 0 0 1 2 7f 00000000 1 12345678
idle
idle
idle

// ==== flist.f ====
rtl/spm_pkg.sv
rtl/spm_config_buffer.sv
rtl/spm_port_mux.sv
rtl/spm_bankgroup.sv
rtl/scratchpad.sv
test/scratchpad_assertions.sv
test/scratchpad_tb.sv

// ==== Bender.yml ====
package:
  name: scratchpad

sources:
  - rtl/spm_pkg.sv
  - rtl/spm_config_buffer.sv
  - rtl/spm_port_mux.sv
  - rtl/spm_bankgroup.sv
  - rtl/scratchpad.sv
  - target: test
    files:
      - test/scratchpad_assertions.sv
      - test/scratchpad_tb.sv
